/* Makefile */
# Verilator build and run of the dispatch queue testbench

VERILATOR ?= verilator
TOP ?= sysu_dq_tb
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= All tests passed!

SOURCES := $(shell grep -v '^+' sim.f)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): sim.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f sim.f

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

/* bench/sysu_dq_checker.sv */
/*
 * checker for the dispatch queue top level. keeps a model of the queue
 * from the wrapper ports alone and compares every ack and every launch
 */
`timescale 1ns/1ps
`default_nettype none

module sysu_dq_checker #(
	parameter int SYSU_DQ_ENTRIES = 4
) (
	input logic CLK,
	input logic nRST,
	input logic [3:0] next_dispatch_attempt_by_way,
	input logic [3:0] next_dispatch_valid_by_way,
	input core_types_pkg::sysu_dispatch_t [3:0] next_dispatch_op_by_way,
	input logic [3:0] last_dispatch_ack_by_way,
	input logic [core_types_pkg::PRF_BANK_COUNT-1:0] next_WB_bus_valid_by_bank,
	input core_types_pkg::upper_pr_t [core_types_pkg::PRF_BANK_COUNT-1:0]
		next_WB_bus_upper_PR_by_bank,
	input logic last_sysu_launch_valid,
	input core_types_pkg::sysu_launch_t last_sysu_launch_op,
	input logic next_sysu_launch_ready,
	input logic next_rob_kill_valid,
	input core_types_pkg::rob_index_t next_rob_kill_abs_head_index,
	input core_types_pkg::rob_index_t next_rob_kill_rel_kill_younger_index,
	output int error_count,
	output int pending_count
);

	import core_types_pkg::*;

	// one cycle of port inputs
	typedef struct packed {
		logic [3:0] attempt;
		logic [3:0] valid;
		sysu_dispatch_t [3:0] ops;
		logic [PRF_BANK_COUNT-1:0] wb_valid;
		upper_pr_t [PRF_BANK_COUNT-1:0] wb_upper;
		logic ready;
		logic kill_valid;
		rob_index_t kill_head;
		rob_index_t kill_rel;
	} input_snap_t;

	typedef struct packed {
		logic A_ready;
		logic B_ready;
		logic killed;
		sysu_dispatch_t op;
	} model_entry_t;

	model_entry_t model_q[$];
	// inputs seen one and two edges back
	input_snap_t snap_d1;
	input_snap_t snap_d2;
	logic [3:0] expected_ack;

	// ----------------------------------------------------------------------
	// reference model

	function automatic sysu_launch_t expected_launch(input model_entry_t e);
		sysu_launch_t l;
		l.killed = e.killed;
		l.op = e.op.op;
		l.imm12 = e.op.imm12;
		l.A_PR = e.op.A_PR;
		l.A_is_zero = e.op.A_is_zero;
		l.B_PR = e.op.B_PR;
		l.B_is_zero = e.op.B_is_zero;
		l.dest_PR = e.op.dest_PR;
		l.ROB_index = e.op.ROB_index;
		return l;
	endfunction

	// low two PR bits pick the bank
	function automatic logic written_back(input pr_t pr, input input_snap_t s);
		return s.wb_valid[pr[1:0]] && (s.wb_upper[pr[1:0]] == pr[6:2]);
	endfunction

	task automatic report_field(input string name, input logic [31:0] want,
		input logic [31:0] got);
		if (want !== got) begin
			$display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, want, got);
			error_count++;
		end
	endtask

	// free slots must outnumber the lower attempting ways
	task automatic check_ack();
		int free_slots;
		int lower;
		free_slots = SYSU_DQ_ENTRIES - model_q.size();
		lower = 0;
		for (int w = 0; w < 4; w++) begin
			expected_ack[w] = snap_d2.attempt[w] && (free_slots > lower);
			if (snap_d2.attempt[w]) begin
				lower++;
			end
		end
		report_field("last_dispatch_ack_by_way", 32'(expected_ack),
			32'(last_dispatch_ack_by_way));
	endtask

	// head goes when ready was high and it is killed or fully woken
	task automatic check_launch();
		model_entry_t head;
		sysu_launch_t want;
		logic want_valid;
		want_valid = 1'b0;
		if (model_q.size() != 0) begin
			head = model_q[0];
			want_valid = snap_d2.ready && (head.killed || (head.A_ready && head.B_ready));
		end
		report_field("last_sysu_launch_valid", 32'(want_valid), 32'(last_sysu_launch_valid));
		if (last_sysu_launch_valid) begin
			if (model_q.size() == 0) begin
				$display("launch at %0t with no op in the queue", $time);
				error_count++;
			end else begin
				head = model_q.pop_front();
				want = expected_launch(head);
				report_field("last_sysu_launch_op.killed", 32'(want.killed),
					32'(last_sysu_launch_op.killed));
				report_field("last_sysu_launch_op.op", 32'(want.op),
					32'(last_sysu_launch_op.op));
				report_field("last_sysu_launch_op.imm12", 32'(want.imm12),
					32'(last_sysu_launch_op.imm12));
				report_field("last_sysu_launch_op.A_PR", 32'(want.A_PR),
					32'(last_sysu_launch_op.A_PR));
				report_field("last_sysu_launch_op.A_is_zero", 32'(want.A_is_zero),
					32'(last_sysu_launch_op.A_is_zero));
				report_field("last_sysu_launch_op.B_PR", 32'(want.B_PR),
					32'(last_sysu_launch_op.B_PR));
				report_field("last_sysu_launch_op.B_is_zero", 32'(want.B_is_zero),
					32'(last_sysu_launch_op.B_is_zero));
				report_field("last_sysu_launch_op.dest_PR", 32'(want.dest_PR),
					32'(last_sysu_launch_op.dest_PR));
				report_field("last_sysu_launch_op.ROB_index", 32'(want.ROB_index),
					32'(last_sysu_launch_op.ROB_index));
			end
		end
	endtask

	task automatic append_and_update();
		model_entry_t e;
		rob_index_t age;
		for (int w = 0; w < 4; w++) begin
			if (expected_ack[w] && snap_d2.valid[w]) begin
				e.op = snap_d2.ops[w];
				e.A_ready = e.op.A_ready | e.op.A_is_zero;
				e.B_ready = e.op.B_ready | e.op.B_is_zero;
				e.killed = 1'b0;
				model_q.push_back(e);
			end
		end
		// writeback and kill reach old and just written entries alike
		foreach (model_q[i]) begin
			e = model_q[i];
			e.A_ready = e.A_ready | written_back(e.op.A_PR, snap_d2);
			e.B_ready = e.B_ready | written_back(e.op.B_PR, snap_d2);
			age = e.op.ROB_index - snap_d2.kill_head;
			e.killed = e.killed | (snap_d2.kill_valid && (age >= snap_d2.kill_rel));
			model_q[i] = e;
		end
	endtask

	// ----------------------------------------------------------------------
	// per edge: outputs now belong to inputs seen two edges back

	always @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			model_q.delete();
			snap_d1 = '0;
			snap_d2 = '0;
			error_count = 0;
			pending_count = 0;
		end else begin
			check_ack();
			check_launch();
			append_and_update();
			snap_d2 = snap_d1;
			snap_d1.attempt = next_dispatch_attempt_by_way;
			snap_d1.valid = next_dispatch_valid_by_way;
			snap_d1.ops = next_dispatch_op_by_way;
			snap_d1.wb_valid = next_WB_bus_valid_by_bank;
			snap_d1.wb_upper = next_WB_bus_upper_PR_by_bank;
			snap_d1.ready = next_sysu_launch_ready;
			snap_d1.kill_valid = next_rob_kill_valid;
			snap_d1.kill_head = next_rob_kill_abs_head_index;
			snap_d1.kill_rel = next_rob_kill_rel_kill_younger_index;
			pending_count = model_q.size();
		end
	end

endmodule

`default_nettype wire

/* bench/sysu_dq_tb.sv */
/*
 * testbench for the dispatch queue top level. runs five phases of random
 * dispatch, writeback, kill and ready traffic, each drained at the end,
 * while the checker instance compares acks and launches
 */
`timescale 1ns/1ps
`default_nettype none

module sysu_dq_tb;

	import core_types_pkg::*;

	localparam int DEPTH = 4;
	localparam int DRAIN_TIMEOUT = 1000;

	logic CLK;
	logic nRST;
	logic [3:0] next_dispatch_attempt_by_way;
	logic [3:0] next_dispatch_valid_by_way;
	sysu_dispatch_t [3:0] next_dispatch_op_by_way;
	logic [3:0] last_dispatch_ack_by_way;
	logic [PRF_BANK_COUNT-1:0] next_WB_bus_valid_by_bank;
	upper_pr_t [PRF_BANK_COUNT-1:0] next_WB_bus_upper_PR_by_bank;
	logic last_sysu_launch_valid;
	sysu_launch_t last_sysu_launch_op;
	logic next_sysu_launch_ready;
	logic next_rob_kill_valid;
	rob_index_t next_rob_kill_abs_head_index;
	rob_index_t next_rob_kill_rel_kill_younger_index;

	int error_count;
	int pending_count;
	int tests_run;
	int tests_failed;
	logic timed_out;
	logic [31:0] rng_state;

	sysu_dq_wrapper #(.SYSU_DQ_ENTRIES(DEPTH)) u_dut (.*);
	sysu_dq_checker #(.SYSU_DQ_ENTRIES(DEPTH)) u_chk (.*);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	// ----------------------------------------------------------------------
	// stimulus

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic next_rand(output logic [31:0] r);
		rng_state = xorshift(rng_state);
		r = rng_state;
	endtask

	// upper PR bits kept small so writebacks hit often
	task automatic make_op(input logic all_ready, output sysu_dispatch_t op);
		logic [31:0] r0;
		logic [31:0] r1;
		next_rand(r0);
		next_rand(r1);
		op.op = r0[3:0];
		op.imm12 = r0[15:4];
		op.A_PR = {3'b000, r0[21:20], r0[19:18]};
		op.B_PR = {3'b000, r0[25:24], r0[23:22]};
		op.dest_PR = r1[6:0];
		op.ROB_index = r1[13:7];
		op.A_is_zero = r1[14] & r1[15];
		op.B_is_zero = r1[16] & r1[17];
		op.A_ready = all_ready | r1[18];
		op.B_ready = all_ready | r1[19];
	endtask

	// ready_mode 0 holds ready high, 1 holds it low, 2 toggles at random
	task automatic drive_cycle(input logic dispatch_en, input logic all_ready,
		input int ready_mode, input logic wb_en, input logic kill_en);
		logic [31:0] r;
		sysu_dispatch_t op;
		@(posedge CLK);
		#1;
		next_rand(r);
		next_dispatch_attempt_by_way = dispatch_en ? r[3:0] : 4'b0000;
		next_dispatch_valid_by_way = r[7:4] | r[11:8];
		for (int w = 0; w < 4; w++) begin
			make_op(all_ready, op);
			next_dispatch_op_by_way[w] = op;
		end
		next_sysu_launch_ready = (ready_mode == 0) || (ready_mode == 2 && r[12]);
		for (int b = 0; b < PRF_BANK_COUNT; b++) begin
			next_WB_bus_valid_by_bank[b] = wb_en & r[16+b];
			next_WB_bus_upper_PR_by_bank[b] = {3'b000, r[20+2*b +: 2]};
		end
		next_rand(r);
		next_rob_kill_valid = kill_en && (r[2:0] == 3'd0);
		next_rob_kill_abs_head_index = r[9:3];
		next_rob_kill_rel_kill_younger_index = r[16:10];
	endtask

	// random traffic, then idle with ready high until the queue is empty
	task automatic run_test(input string name, input int cycles, input logic all_ready,
		input int ready_mode, input logic wb_en, input logic kill_en);
		int errors_before;
		int idle;
		if (timed_out) begin
			return;
		end
		errors_before = error_count;
		for (int c = 0; c < cycles; c++) begin
			drive_cycle(1'b1, all_ready, ready_mode, wb_en, kill_en);
		end
		idle = 0;
		while (!timed_out && (idle < 4 || pending_count != 0)) begin
			drive_cycle(1'b0, 1'b1, 0, 1'b1, 1'b0);
			idle++;
			if (idle > DRAIN_TIMEOUT) begin
				timed_out = 1'b1;
				$display("%s: queue did not drain within %0d cycles", name, DRAIN_TIMEOUT);
			end
		end
		tests_run++;
		if (timed_out || error_count != errors_before) begin
			tests_failed++;
			$display("test %s FAILED, %0d errors", name, error_count - errors_before);
		end else begin
			$display("test %s ok", name);
		end
	endtask

	// ----------------------------------------------------------------------
	// test sequence

	initial begin
		nRST = 1'b0;
		next_dispatch_attempt_by_way = '0;
		next_dispatch_valid_by_way = '0;
		next_dispatch_op_by_way = '0;
		next_WB_bus_valid_by_bank = '0;
		next_WB_bus_upper_PR_by_bank = '0;
		next_sysu_launch_ready = 1'b0;
		next_rob_kill_valid = 1'b0;
		next_rob_kill_abs_head_index = '0;
		next_rob_kill_rel_kill_younger_index = '0;
		rng_state = 32'h84bc_2f0e;
		timed_out = 1'b0;
		tests_run = 0;
		tests_failed = 0;
		repeat (5) @(posedge CLK);
		#1;
		nRST = 1'b1;

		run_test("order", 60, 1'b1, 0, 1'b0, 1'b0);
		run_test("acceptance", 20, 1'b1, 1, 1'b0, 1'b0);
		run_test("wakeup", 80, 1'b0, 0, 1'b1, 1'b0);
		run_test("kill", 80, 1'b0, 0, 1'b1, 1'b1);
		run_test("backpressure", 150, 1'b0, 2, 1'b1, 1'b0);

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
		if (timed_out || tests_failed != 0 || error_count != 0) begin
			$display("Test failures found");
		end else begin
			$display("All tests passed!");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* design/core_types_pkg.sv */
/*
 * shared widths, vector types and op records for the system unit
 * dispatch queue. compiled ahead of the RTL and the testbench, which
 * pull in what they need from it
 */
`default_nettype none

package core_types_pkg;

	// ----------------------------------------------------------------------
	// widths

	// physical register number, low bits pick the writeback bank
	localparam int LOG_PR_COUNT = 7;
	localparam int LOG_ROB_ENTRIES = 7;
	localparam int PRF_BANK_COUNT = 4;
	localparam int LOG_PRF_BANK_COUNT = 2;

	// ----------------------------------------------------------------------
	// vector types

	typedef logic [LOG_PR_COUNT-1:0] pr_t;
	// register number with bank bits stripped, as carried on a WB bus
	typedef logic [LOG_PR_COUNT-LOG_PRF_BANK_COUNT-1:0] upper_pr_t;
	typedef logic [LOG_ROB_ENTRIES-1:0] rob_index_t;
	typedef logic [3:0] sysu_op_t;
	typedef logic [11:0] imm12_t;

	// ----------------------------------------------------------------------
	// op records

	// one op offered by a dispatch way
	typedef struct packed {
		sysu_op_t op;
		imm12_t imm12;
		pr_t A_PR;
		logic A_ready;
		logic A_is_zero;
		pr_t B_PR;
		logic B_ready;
		logic B_is_zero;
		pr_t dest_PR;
		rob_index_t ROB_index;
	} sysu_dispatch_t;

	// one op sent to the system unit
	typedef struct packed {
		logic killed;
		sysu_op_t op;
		imm12_t imm12;
		pr_t A_PR;
		logic A_is_zero;
		pr_t B_PR;
		logic B_is_zero;
		pr_t dest_PR;
		rob_index_t ROB_index;
	} sysu_launch_t;

endpackage

`default_nettype wire

/* design/sysu_dq.sv */
/*
 * in-order dispatch queue in front of the system unit. takes up to four
 * ops per cycle, wakes operands from the banked writeback buses, marks
 * killed entries and launches the head op under valid/ready
 */
`timescale 1ns/1ps
`default_nettype none

module sysu_dq #(
	parameter int SYSU_DQ_ENTRIES = 4
) (
	input logic CLK,
	input logic nRST,

	// dispatch by way
	input logic [3:0] dispatch_attempt_by_way,
	input logic [3:0] dispatch_valid_by_way,
	input core_types_pkg::sysu_dispatch_t [3:0] dispatch_op_by_way,
	output logic [3:0] dispatch_ack_by_way,

	// writeback bus by bank
	input logic [core_types_pkg::PRF_BANK_COUNT-1:0] WB_bus_valid_by_bank,
	input core_types_pkg::upper_pr_t [core_types_pkg::PRF_BANK_COUNT-1:0]
		WB_bus_upper_PR_by_bank,

	// launch to system unit
	output logic sysu_launch_valid,
	output core_types_pkg::sysu_launch_t sysu_launch_op,
	input logic sysu_launch_ready,

	// ROB kill
	input logic rob_kill_valid,
	input core_types_pkg::rob_index_t rob_kill_abs_head_index,
	input core_types_pkg::rob_index_t rob_kill_rel_kill_younger_index
);

	import core_types_pkg::*;

	// counters must also hold the way count
	localparam int ENTRY_COUNT_W = $clog2(SYSU_DQ_ENTRIES + 1);
	localparam int COUNT_W = (ENTRY_COUNT_W > 3) ? ENTRY_COUNT_W : 3;
	localparam logic [COUNT_W-1:0] DEPTH = COUNT_W'(SYSU_DQ_ENTRIES);

	typedef struct packed {
		logic valid;
		logic A_ready;
		logic B_ready;
		logic killed;
	} dq_flags_t;

	// entry 0 is the oldest, valid entries are packed from 0 upward
	dq_flags_t [SYSU_DQ_ENTRIES-1:0] entry_flags;
	dq_flags_t [SYSU_DQ_ENTRIES-1:0] next_entry_flags;
	sysu_dispatch_t [SYSU_DQ_ENTRIES-1:0] entry_op;
	sysu_dispatch_t [SYSU_DQ_ENTRIES-1:0] next_entry_op;

	logic [COUNT_W-1:0] entry_count;
	logic [COUNT_W-1:0] free_count;
	logic [COUNT_W-1:0] attempt_count;
	logic [COUNT_W-1:0] ack_count;
	logic [COUNT_W-1:0] write_ptr;

	// ----------------------------------------------------------------------
	// helpers

	// bank is picked by the low PR bits, the bus carries the rest
	function automatic logic wb_hit(
		input pr_t pr,
		input logic [PRF_BANK_COUNT-1:0] bus_valid,
		input upper_pr_t [PRF_BANK_COUNT-1:0] bus_upper
	);
		logic [LOG_PRF_BANK_COUNT-1:0] bank;
		bank = pr[LOG_PRF_BANK_COUNT-1:0];
		return bus_valid[bank] && (bus_upper[bank] == pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT]);
	endfunction

	// age relative to ROB head, wraps with the index width
	function automatic logic kill_hit(
		input rob_index_t rob_index,
		input logic kill_valid,
		input rob_index_t head_index,
		input rob_index_t rel_index
	);
		rob_index_t age;
		age = rob_index - head_index;
		return kill_valid && (age >= rel_index);
	endfunction

	// ----------------------------------------------------------------------
	// occupancy and dispatch ack

	always_comb begin
		entry_count = '0;
		for (int i = 0; i < SYSU_DQ_ENTRIES; i++) begin
			if (entry_flags[i].valid) begin
				entry_count = entry_count + 1'b1;
			end
		end
	end

	assign free_count = DEPTH - entry_count;

	// way acked while free slots outnumber lower attempting ways
	always_comb begin
		attempt_count = '0;
		ack_count = '0;
		for (int w = 0; w < 4; w++) begin
			dispatch_ack_by_way[w] = dispatch_attempt_by_way[w] && (free_count > attempt_count);
			if (dispatch_attempt_by_way[w]) begin
				attempt_count = attempt_count + 1'b1;
			end
			if (dispatch_ack_by_way[w]) begin
				ack_count = ack_count + 1'b1;
			end
		end
	end

	// ----------------------------------------------------------------------
	// head launch

	// killed ops skip the operand wait
	assign sysu_launch_valid = entry_flags[0].valid && sysu_launch_ready
		&& (entry_flags[0].killed || (entry_flags[0].A_ready && entry_flags[0].B_ready));

	always_comb begin
		sysu_launch_op.killed = entry_flags[0].killed;
		sysu_launch_op.op = entry_op[0].op;
		sysu_launch_op.imm12 = entry_op[0].imm12;
		sysu_launch_op.A_PR = entry_op[0].A_PR;
		sysu_launch_op.A_is_zero = entry_op[0].A_is_zero;
		sysu_launch_op.B_PR = entry_op[0].B_PR;
		sysu_launch_op.B_is_zero = entry_op[0].B_is_zero;
		sysu_launch_op.dest_PR = entry_op[0].dest_PR;
		sysu_launch_op.ROB_index = entry_op[0].ROB_index;
	end

	// ----------------------------------------------------------------------
	// next queue state

	always_comb begin
		next_entry_flags = entry_flags;
		next_entry_op = entry_op;

		// launched head leaves, the rest move up one slot
		if (sysu_launch_valid) begin
			for (int i = 0; i < SYSU_DQ_ENTRIES - 1; i++) begin
				next_entry_flags[i] = entry_flags[i+1];
				next_entry_op[i] = entry_op[i+1];
			end
			next_entry_flags[SYSU_DQ_ENTRIES-1] = '0;
		end

		// append acked valid ways behind the survivors, in way order
		write_ptr = entry_count - COUNT_W'(sysu_launch_valid);
		for (int w = 0; w < 4; w++) begin
			if (dispatch_ack_by_way[w] && dispatch_valid_by_way[w]) begin
				for (int i = 0; i < SYSU_DQ_ENTRIES; i++) begin
					if (COUNT_W'(i) == write_ptr) begin
						next_entry_flags[i].valid = 1'b1;
						next_entry_flags[i].A_ready = dispatch_op_by_way[w].A_ready
							| dispatch_op_by_way[w].A_is_zero;
						next_entry_flags[i].B_ready = dispatch_op_by_way[w].B_ready
							| dispatch_op_by_way[w].B_is_zero;
						next_entry_flags[i].killed = 1'b0;
						next_entry_op[i] = dispatch_op_by_way[w];
					end
				end
				write_ptr = write_ptr + 1'b1;
			end
		end

		// wakeup and kill cover old and freshly written entries alike
		for (int i = 0; i < SYSU_DQ_ENTRIES; i++) begin
			if (next_entry_flags[i].valid) begin
				next_entry_flags[i].A_ready = next_entry_flags[i].A_ready
					| wb_hit(next_entry_op[i].A_PR, WB_bus_valid_by_bank,
						WB_bus_upper_PR_by_bank);
				next_entry_flags[i].B_ready = next_entry_flags[i].B_ready
					| wb_hit(next_entry_op[i].B_PR, WB_bus_valid_by_bank,
						WB_bus_upper_PR_by_bank);
				next_entry_flags[i].killed = next_entry_flags[i].killed
					| kill_hit(next_entry_op[i].ROB_index, rob_kill_valid,
						rob_kill_abs_head_index, rob_kill_rel_kill_younger_index);
			end
		end
	end

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			entry_flags <= '0;
		end else begin
			entry_flags <= next_entry_flags;
		end
	end

	always_ff @(posedge CLK) begin
		entry_op <= next_entry_op;
	end

	// ----------------------------------------------------------------------
	// checks

	// live entries stay packed behind the head, so a launch takes the oldest
	for (genvar i = 1; i < SYSU_DQ_ENTRIES; i++) begin : g_packed_chk
		assert property (@(posedge CLK) disable iff (!nRST)
			entry_flags[i].valid |-> entry_flags[i-1].valid);
	end

	// acked slots plus current entries fit in the queue
	assert property (@(posedge CLK) disable iff (!nRST)
		(int'(entry_count) + int'(ack_count)) <= SYSU_DQ_ENTRIES);

	// queue grows by the acked valid ways and shrinks by the launch
	assert property (@(posedge CLK) disable iff (!nRST)
		int'(entry_count) == int'($past(entry_count)) - int'($past(sysu_launch_valid))
			+ $countones($past(dispatch_ack_by_way & dispatch_valid_by_way)));

endmodule

`default_nettype wire

/* design/sysu_dq_wrapper.sv */
/*
 * top level around the system unit dispatch queue. every input and
 * output goes through one register stage so the queue can be timed
 * on its own
 */
`timescale 1ns/1ps
`default_nettype none

module sysu_dq_wrapper #(
	parameter int SYSU_DQ_ENTRIES = 4
) (
	input logic CLK,
	input logic nRST,

	// dispatch by way
	input logic [3:0] next_dispatch_attempt_by_way,
	input logic [3:0] next_dispatch_valid_by_way,
	input core_types_pkg::sysu_dispatch_t [3:0] next_dispatch_op_by_way,
	output logic [3:0] last_dispatch_ack_by_way,

	// writeback bus by bank
	input logic [core_types_pkg::PRF_BANK_COUNT-1:0] next_WB_bus_valid_by_bank,
	input core_types_pkg::upper_pr_t [core_types_pkg::PRF_BANK_COUNT-1:0]
		next_WB_bus_upper_PR_by_bank,

	// launch to system unit
	output logic last_sysu_launch_valid,
	output core_types_pkg::sysu_launch_t last_sysu_launch_op,
	input logic next_sysu_launch_ready,

	// ROB kill
	input logic next_rob_kill_valid,
	input core_types_pkg::rob_index_t next_rob_kill_abs_head_index,
	input core_types_pkg::rob_index_t next_rob_kill_rel_kill_younger_index
);

	import core_types_pkg::*;

	// ----------------------------------------------------------------------
	// queue side signals

	logic [3:0] dispatch_attempt_by_way;
	logic [3:0] dispatch_valid_by_way;
	sysu_dispatch_t [3:0] dispatch_op_by_way;
	logic [3:0] dispatch_ack_by_way;

	logic [PRF_BANK_COUNT-1:0] WB_bus_valid_by_bank;
	upper_pr_t [PRF_BANK_COUNT-1:0] WB_bus_upper_PR_by_bank;

	logic sysu_launch_valid;
	sysu_launch_t sysu_launch_op;
	logic sysu_launch_ready;

	logic rob_kill_valid;
	rob_index_t rob_kill_abs_head_index;
	rob_index_t rob_kill_rel_kill_younger_index;

	sysu_dq #(
		.SYSU_DQ_ENTRIES(SYSU_DQ_ENTRIES)
	) wrapped_dq (
		.CLK(CLK),
		.nRST(nRST),
		.dispatch_attempt_by_way(dispatch_attempt_by_way),
		.dispatch_valid_by_way(dispatch_valid_by_way),
		.dispatch_op_by_way(dispatch_op_by_way),
		.dispatch_ack_by_way(dispatch_ack_by_way),
		.WB_bus_valid_by_bank(WB_bus_valid_by_bank),
		.WB_bus_upper_PR_by_bank(WB_bus_upper_PR_by_bank),
		.sysu_launch_valid(sysu_launch_valid),
		.sysu_launch_op(sysu_launch_op),
		.sysu_launch_ready(sysu_launch_ready),
		.rob_kill_valid(rob_kill_valid),
		.rob_kill_abs_head_index(rob_kill_abs_head_index),
		.rob_kill_rel_kill_younger_index(rob_kill_rel_kill_younger_index)
	);

	// ----------------------------------------------------------------------
	// boundary registers

	// ready clears too, so nothing launches right after reset
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			dispatch_attempt_by_way <= '0;
			dispatch_valid_by_way <= '0;
			dispatch_op_by_way <= '0;
			WB_bus_valid_by_bank <= '0;
			WB_bus_upper_PR_by_bank <= '0;
			sysu_launch_ready <= 1'b0;
			rob_kill_valid <= 1'b0;
			rob_kill_abs_head_index <= '0;
			rob_kill_rel_kill_younger_index <= '0;
			last_dispatch_ack_by_way <= '0;
			last_sysu_launch_valid <= 1'b0;
			last_sysu_launch_op <= '0;
		end else begin
			// inputs
			dispatch_attempt_by_way <= next_dispatch_attempt_by_way;
			dispatch_valid_by_way <= next_dispatch_valid_by_way;
			dispatch_op_by_way <= next_dispatch_op_by_way;
			WB_bus_valid_by_bank <= next_WB_bus_valid_by_bank;
			WB_bus_upper_PR_by_bank <= next_WB_bus_upper_PR_by_bank;
			sysu_launch_ready <= next_sysu_launch_ready;
			rob_kill_valid <= next_rob_kill_valid;
			rob_kill_abs_head_index <= next_rob_kill_abs_head_index;
			rob_kill_rel_kill_younger_index <= next_rob_kill_rel_kill_younger_index;
			// outputs
			last_dispatch_ack_by_way <= dispatch_ack_by_way;
			last_sysu_launch_valid <= sysu_launch_valid;
			last_sysu_launch_op <= sysu_launch_op;
		end
	end

endmodule

`default_nettype wire

/* sim.f */
design/core_types_pkg.sv
design/sysu_dq.sv
design/sysu_dq_wrapper.sv
bench/sysu_dq_checker.sv
bench/sysu_dq_tb.sv
